/* all.f */
source/rvIsaPkg.sv
source/corePkg.sv
source/coreIfs.sv
source/bundleFetch.sv
source/issueDecode.sv
source/aluLane.sv
source/regFileWb.sv
source/vliwCore.sv
sim/vliwCore_props.sv
sim/vliwCoreTb.sv

/* Makefile */
TOP = vliwCoreTb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* sim/vliwCoreTb.sv */
/*
  Two-lane testbench with a 64-bundle Wishbone memory model.
  First 16 bundles get ack with no wait, the rest 0 to 3 wait cycles.
  Run drops twice mid-stream. Stops at the first mismatch.
*/
module vliwCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvIsaPkg::*;
  import corePkg::*;

  localparam int LANES       = 2;
  localparam int ADDR_W      = 6;
  localparam int NUM_BUNDLES = 64;
  localparam int CYCLE_LIMIT = NUM_BUNDLES * (3 + 2 + 3) + 50;

  logic clk, rstN, run, wbCyc, wbStb, wbAck;
  logic [ADDR_W-1:0]    wbAdr;
  instr_t [LANES-1:0]   wbDatIn;
  logic [LANES-1:0]     retireValid;
  regAddr_t [LANES-1:0] retireRd;
  word_t [LANES-1:0]    retireData;

  instr_t [LANES-1:0]   mem [NUM_BUNDLES];
  word_t                modelRegs [32];
  logic [LANES-1:0]     expValidQ [$];
  regAddr_t [LANES-1:0] expRdQ [$];
  word_t [LANES-1:0]    expDataQ [$];
  int accepted, pauseCnt, waitCnt, cycleCnt;
  logic busy;

  vliwCore #(.LANES(LANES), .ADDR_W(ADDR_W)) vliwCore_inst (
    .clk, .rstN, .run, .wbCyc, .wbStb, .wbAdr, .wbDatIn, .wbAck,
    .retireValid, .retireRd, .retireData
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValid(input string name, input logic exp, input logic got);
    if (got !== exp) failRun($sformatf("ERR %s exp 0x%0h got 0x%0h", name, exp, got));
  endtask

  task automatic checkRd(input string name, input regAddr_t exp, input regAddr_t got);
    if (got !== exp) failRun($sformatf("ERR %s exp 0x%02h got 0x%02h", name, exp, got));
  endtask

  task automatic checkWord(input string name, input word_t exp, input word_t got);
    if (got !== exp) failRun($sformatf("ERR %s exp 0x%08h got 0x%08h", name, exp, got));
  endtask

  task automatic checkAddr(input string name, input logic [ADDR_W-1:0] exp,
                           input logic [ADDR_W-1:0] got);
    if (got !== exp) failRun($sformatf("ERR %s exp 0x%02h got 0x%02h", name, exp, got));
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction encoding and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic instr_t rType(funct7_t f7, regAddr_t rs2, regAddr_t rs1, funct3_t f3,
                                   regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic instr_t iType(logic [11:0] imm, regAddr_t rs1, funct3_t f3, regAddr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic instr_t randomWord();
    int unsigned kind;
    regAddr_t rd, rs1, rs2;
    funct3_t f3;
    funct7_t f7;
    kind = $urandom % 8;
    rd   = regAddr_t'($urandom % 16); // small range, more dependencies
    rs1  = regAddr_t'($urandom % 16);
    rs2  = regAddr_t'($urandom % 16);
    f3   = funct3_t'($urandom);
    f7   = ($urandom % 4 == 0) ? F7_ALT : F7_BASE;
    if (kind < 4) return rType(f7, rs2, rs1, f3, rd);
    if (kind < 7) begin
      if (f3 == F3_SLL || f3 == F3_SRL) return iType({f7, rs2}, rs1, f3, rd);
      return iType(12'($urandom), rs1, f3, rd);
    end
    return $urandom; // mostly illegal
  endfunction

  // returns 1 for a legal ALU word, result in res
  function automatic logic refExec(input instr_t w, input word_t a, input word_t rb,
                                   output word_t res);
    funct7_t f7;
    funct3_t f3;
    logic    isImm;
    word_t   b;
    f7    = w[31:25];
    f3    = w[14:12];
    isImm = (w[6:0] == OPC_OP_IMM);
    res   = '0;
    if (w[6:0] != OPC_OP && !isImm) return 1'b0;
    b = isImm ? {{20{w[31]}}, w[31:20]} : rb;
    if (!isImm || f3 == F3_SLL || f3 == F3_SRL) begin
      if (f7 != F7_BASE && !(f7 == F7_ALT && (f3 == F3_SRL || (f3 == F3_ADD && !isImm))))
        return 1'b0;
    end
    case (f3)
      F3_ADD:  res = (!isImm && f7 == F7_ALT) ? a - b : a + b;
      F3_SLL:  res = a << b[4:0];
      F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  res = a ^ b;
      F3_SRL: begin
        if (f7 == F7_ALT) res = $signed(a) >>> b[4:0];
        else res = a >> b[4:0];
      end
      F3_OR:   res = a | b;
      default: res = a & b;
    endcase
    return 1'b1;
  endfunction

  // all lanes read old state, then write in lane order
  function automatic void predictBundle(input instr_t [LANES-1:0] b);
    logic [LANES-1:0]     v;
    regAddr_t [LANES-1:0] rdv;
    word_t [LANES-1:0]    dv;
    word_t                res;
    logic                 ok;
    for (int l = 0; l < LANES; l++) begin
      rdv[l] = b[l][11:7];
      ok     = refExec(b[l], modelRegs[b[l][19:15]], modelRegs[b[l][24:20]], res);
      v[l]   = ok && (rdv[l] != '0);
      dv[l]  = res;
    end
    for (int l = 0; l < LANES; l++) begin
      if (v[l]) modelRegs[rdv[l]] = dv[l];
    end
    if (v != '0) begin
      expValidQ.push_back(v);
      expRdQ.push_back(rdv);
      expDataQ.push_back(dv);
    end
  endfunction

  task automatic fillMemory();
    mem[0] = {iType(12'd7, 5'd0, F3_ADD, 5'd2), iType(12'hFFB, 5'd0, F3_ADD, 5'd1)};
    mem[1] = {rType(F7_BASE, 5'd2, 5'd1, F3_SLTU, 5'd4), rType(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd3)};
    mem[2] = {rType(F7_ALT, 5'd2, 5'd1, F3_SRL, 5'd6), iType({F7_ALT, 5'd1}, 5'd1, F3_SRL, 5'd5)};
    mem[3] = {rType(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd7), rType(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd7)};
    mem[4] = {iType(12'd0, 5'd2, F3_ADD, 5'd10), iType(12'd0, 5'd7, F3_ADD, 5'd2)};
    mem[5] = {32'hFFFF_FFFF, rType(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0)};
    mem[6] = {rType(7'h01, 5'd2, 5'd1, F3_ADD, 5'd12), rType(F7_BASE, 5'd1, 5'd0, F3_OR, 5'd11)};
    mem[7] = {rType(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd13), iType(12'h123, 5'd0, F3_XOR, 5'd0)};
    mem[8] = {iType(12'd3, 5'd1, F3_SLL, 5'd15), rType(F7_BASE, 5'd2, 5'd1, F3_SRL, 5'd14)};
    for (int a = 9; a < NUM_BUNDLES; a++) begin
      for (int l = 0; l < LANES; l++) mem[a][l] = randomWord();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus slave, run control and retire checker
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #2;
    if (wbAck) begin // sampled by the DUT at this edge
      wbAck = 1'b0;
      busy  = 1'b0;
      accepted++;
      predictBundle(wbDatIn);
      if (accepted == 20 || accepted == 40) pauseCnt = 8;
    end else if (wbCyc && wbStb) begin
      if (!busy) begin
        checkAddr("wbAdr", ADDR_W'(accepted), wbAdr); // one address per bundle
        busy    = 1'b1;
        waitCnt = (wbAdr < 16) ? 0 : int'($urandom % 4);
      end
      if (waitCnt == 0) begin
        wbAck   = 1'b1;
        wbDatIn = mem[wbAdr];
      end else begin
        waitCnt--;
      end
    end
    if (pauseCnt > 0) pauseCnt--;
    run = (accepted < NUM_BUNDLES) && (pauseCnt == 0);
  end

  always @(negedge clk) begin
    if (rstN && (|retireValid)) begin
      if (expValidQ.size() == 0) begin
        failRun("retire seen with no bundle outstanding");
      end else begin
        logic [LANES-1:0]     expV;
        regAddr_t [LANES-1:0] expRd;
        word_t [LANES-1:0]    expD;
        expV  = expValidQ.pop_front();
        expRd = expRdQ.pop_front();
        expD  = expDataQ.pop_front();
        for (int l = 0; l < LANES; l++) begin
          checkValid($sformatf("retireValid[%0d]", l), expV[l], retireValid[l]);
          if (expV[l]) begin
            checkRd($sformatf("retireRd[%0d]", l), expRd[l], retireRd[l]);
            checkWord($sformatf("retireData[%0d]", l), expD[l], retireData[l]);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= CYCLE_LIMIT) failRun("timeout, bundles did not all retire in time");
  end

  initial begin
    void'($urandom(51424));
    rstN     = 1'b0;
    run      = 1'b0;
    wbAck    = 1'b0;
    wbDatIn  = '0;
    busy     = 1'b0;
    accepted = 0;
    pauseCnt = 0;
    waitCnt  = 0;
    cycleCnt = 0;
    for (int r = 0; r < 32; r++) modelRegs[r] = '0;
    fillMemory();
    repeat (5) @(posedge clk);
    #2 rstN = 1'b1;
    while (accepted < NUM_BUNDLES) @(posedge clk);
    repeat (6) @(posedge clk); // drain the pipeline
    if (expValidQ.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      failRun($sformatf("%0d expected retires never appeared", expValidQ.size()));
    end
  end

endmodule

/* sim/vliwCore_props.sv */
/*
  Bus and retire protocol checks, bound into vliwCore.
  Assumes a single outstanding Wishbone classic read at a time.
*/
module vliwCore_props #(
  parameter int ADDR_W = 8,
  parameter int LANES  = 2
) (
  input logic              clk,
  input logic              rstN,
  input logic              wbCyc,
  input logic              wbStb,
  input logic [ADDR_W-1:0] wbAdr,
  input logic              wbAck,
  input logic [LANES-1:0]  retireValid
);
  timeunit 1ns;
  timeprecision 1ps;

  stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
    else $error("wbStb high without wbCyc");

  // request held until the slave acks
  stbHeld: assert property (@(posedge clk) disable iff (!rstN)
    wbStb && !wbAck |=> wbStb && $stable(wbAdr))
    else $error("wbStb or wbAdr changed before ack");

  gapAfterAck: assert property (@(posedge clk) disable iff (!rstN) wbStb && wbAck |=> !wbStb)
    else $error("no idle cycle after ack");

  retireKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(retireValid))
    else $error("retireValid unknown after reset");

endmodule

bind vliwCore vliwCore_props #(.ADDR_W(ADDR_W), .LANES(LANES)) vliwCore_props_inst (
  .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
  .wbAck(wbAck), .retireValid(retireValid)
);

/* source/vliwCore.sv */
/*
  Multi-lane RV32I integer execute cluster, fed over Wishbone classic.
  LANES 1 to 4, ADDR_W 4 to 30. Only ALU register and immediate ops execute.
  A bundle acked at edge E0 retires after E0+2 and is written at E0+3.
*/
module vliwCore #(
  parameter int LANES  = corePkg::DEFAULT_LANES,
  parameter int ADDR_W = 8
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           run,
  output logic                           wbCyc,
  output logic                           wbStb,
  output logic [ADDR_W-1:0]              wbAdr,
  input  rvIsaPkg::instr_t [LANES-1:0]   wbDatIn,
  input  logic                           wbAck,
  output logic [LANES-1:0]               retireValid,
  output rvIsaPkg::regAddr_t [LANES-1:0] retireRd,
  output corePkg::word_t [LANES-1:0]     retireData
);
  import rvIsaPkg::*;

  logic                 bundleValid;
  instr_t [LANES-1:0]   bundle;

  laneIssueIf           issueBus [LANES] ();
  regReadIf #(.LANES(LANES)) readBus ();

  bundleFetch #(.LANES(LANES), .ADDR_W(ADDR_W)) bundleFetch_inst (
    .clk, .rstN, .run,
    .wbCyc, .wbStb, .wbAdr, .wbDatIn, .wbAck,
    .bundleValid, .bundle
  );

  issueDecode #(.LANES(LANES)) issueDecode_inst (
    .clk, .rstN, .bundleValid, .bundle,
    .rd(readBus), .issue(issueBus)
  );

  // retire ports are the lane result registers themselves
  for (genvar l = 0; l < LANES; l++) begin : laneGen
    aluLane aluLane_inst (
      .clk, .rstN,
      .issue(issueBus[l]),
      .resValid(retireValid[l]),
      .resRd(retireRd[l]),
      .resData(retireData[l])
    );
  end

  regFileWb #(.LANES(LANES)) regFileWb_inst (
    .clk, .rstN, .rd(readBus),
    .resValid(retireValid), .resRd(retireRd), .resData(retireData)
  );

endmodule

/* source/regFileWb.sv */
/*
  32 x 32-bit register file, 2*LANES read ports and LANES write ports.
  Same-register writes in one cycle go to the highest lane.
  Reads see pending lane results, so a bundle right behind needs no stall.
*/
module regFileWb #(
  parameter int LANES = corePkg::DEFAULT_LANES
) (
  input  logic                           clk,
  input  logic                           rstN,
  regReadIf.file                         rd,
  input  logic [LANES-1:0]               resValid,
  input  rvIsaPkg::regAddr_t [LANES-1:0] resRd,
  input  corePkg::word_t [LANES-1:0]     resData
);
  import corePkg::*;

  word_t regs [31:1]; // x0 is not stored

  //////////////////////////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int r = 1; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // ascending order, so the last lane written wins
      for (int l = 0; l < LANES; l++) begin
        if (resValid[l] && resRd[l] != '0) begin
          regs[resRd[l]] <= resData[l];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read ports with bypass
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int p = 0; p < 2*LANES; p++) begin
      if (rd.addr[p] == '0) begin
        rd.data[p] = '0;
      end else begin
        rd.data[p] = regs[rd.addr[p]];
        for (int l = 0; l < LANES; l++) begin
          if (resValid[l] && resRd[l] == rd.addr[p]) begin
            rd.data[p] = resData[l]; // pending write
          end
        end
      end
    end
  end

endmodule

/* source/aluLane.sv */
/*
  One integer ALU lane with its result register.
  Shifts use the low five bits of srcB. Unknown op codes give zero.
*/
module aluLane (
  input  logic               clk,
  input  logic               rstN,
  laneIssueIf.lane           issue,
  output logic               resValid,
  output rvIsaPkg::regAddr_t resRd,
  output corePkg::word_t     resData
);
  import rvIsaPkg::*;
  import corePkg::*;

  word_t      result;
  logic [4:0] shamt;

  assign shamt = issue.srcB[4:0];

  always_comb begin
    case (issue.op)
      ALU_ADD:  result = issue.srcA + issue.srcB;
      ALU_SUB:  result = issue.srcA - issue.srcB;
      ALU_SLL:  result = issue.srcA << shamt;
      ALU_SLT:  result = {31'b0, $signed(issue.srcA) < $signed(issue.srcB)};
      ALU_SLTU: result = {31'b0, issue.srcA < issue.srcB};
      ALU_XOR:  result = issue.srcA ^ issue.srcB;
      ALU_SRL:  result = issue.srcA >> shamt;
      ALU_SRA:  result = $signed(issue.srcA) >>> shamt; // sign fill
      ALU_OR:   result = issue.srcA | issue.srcB;
      ALU_AND:  result = issue.srcA & issue.srcB;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else begin
      resValid <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    resRd   <= issue.rd;
    resData <= result;
  end

endmodule

/* source/issueDecode.sv */
/*
  Decodes a bundle lane by lane and loads the issue slots.
  Operands come from the register file read ports with bypass already applied.
  Illegal words and writes to x0 leave the slot invalid.
*/
module issueDecode #(
  parameter int LANES = corePkg::DEFAULT_LANES
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         bundleValid,
  input  rvIsaPkg::instr_t [LANES-1:0] bundle,
  regReadIf.request                    rd,
  laneIssueIf.issue                    issue [LANES]
);
  import rvIsaPkg::*;
  import corePkg::*;

  for (genvar l = 0; l < LANES; l++) begin : laneGen
    instr_t   word;
    opcode_t  opc;
    funct3_t  f3;
    funct7_t  f7;
    regAddr_t dst;
    aluOp_t   op;
    logic     useImm;
    word_t    imm;

    assign word = bundle[l];
    assign opc  = word[6:0];
    assign f3   = word[14:12];
    assign f7   = word[31:25];
    assign dst  = word[11:7];

    assign rd.addr[2*l]   = word[19:15]; // rs1
    assign rd.addr[2*l+1] = word[24:20]; // rs2

    always_comb begin
      op     = ALU_NOP;
      useImm = 1'b0;
      imm    = {{20{word[31]}}, word[31:20]};
      if (opc == OPC_OP) begin
        case ({f7, f3})
          {F7_BASE, F3_ADD}:  op = ALU_ADD;
          {F7_ALT,  F3_ADD}:  op = ALU_SUB;
          {F7_BASE, F3_SLL}:  op = ALU_SLL;
          {F7_BASE, F3_SLT}:  op = ALU_SLT;
          {F7_BASE, F3_SLTU}: op = ALU_SLTU;
          {F7_BASE, F3_XOR}:  op = ALU_XOR;
          {F7_BASE, F3_SRL}:  op = ALU_SRL;
          {F7_ALT,  F3_SRL}:  op = ALU_SRA;
          {F7_BASE, F3_OR}:   op = ALU_OR;
          {F7_BASE, F3_AND}:  op = ALU_AND;
          default:            op = ALU_NOP;
        endcase
      end else if (opc == OPC_OP_IMM) begin
        useImm = 1'b1;
        case (f3)
          F3_ADD:  op = ALU_ADD;
          F3_SLT:  op = ALU_SLT;
          F3_SLTU: op = ALU_SLTU;
          F3_XOR:  op = ALU_XOR;
          F3_OR:   op = ALU_OR;
          F3_AND:  op = ALU_AND;
          F3_SLL:  op = (f7 == F7_BASE) ? ALU_SLL : ALU_NOP;
          F3_SRL:  op = (f7 == F7_BASE) ? ALU_SRL : (f7 == F7_ALT) ? ALU_SRA : ALU_NOP;
          default: op = ALU_NOP;
        endcase
        if (f3 == F3_SLL || f3 == F3_SRL) begin
          imm = {27'b0, word[24:20]}; // shamt only
        end
      end
    end

    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        issue[l].valid <= 1'b0;
      end else begin
        issue[l].valid <= bundleValid && (op != ALU_NOP) && (dst != '0);
      end
    end

    always_ff @(posedge clk) begin
      issue[l].op   <= op;
      issue[l].srcA <= rd.data[2*l];
      issue[l].srcB <= useImm ? imm : rd.data[2*l+1];
      issue[l].rd   <= dst;
    end
  end

endmodule

/* source/bundleFetch.sv */
/*
  Read-only Wishbone classic master, one bundle per bus cycle.
  Addresses count bundles from 0 and wrap at 2**ADDR_W.
  Cyc/stb always drop for one cycle after each ack.
*/
module bundleFetch #(
  parameter int LANES  = corePkg::DEFAULT_LANES,
  parameter int ADDR_W = 8
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         run,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic [ADDR_W-1:0]            wbAdr,
  input  rvIsaPkg::instr_t [LANES-1:0] wbDatIn,
  input  logic                         wbAck,
  output logic                         bundleValid,
  output rvIsaPkg::instr_t [LANES-1:0] bundle
);
  import corePkg::*;

  fetchState_e state;
  fetchState_e stateNext;
  logic        ackSeen;

  assign ackSeen = (state == FETCH_REQ) && wbAck;
  assign wbCyc   = (state == FETCH_REQ);
  assign wbStb   = wbCyc;

  always_comb begin
    stateNext = state;
    case (state)
      FETCH_IDLE: if (run) stateNext = FETCH_REQ;
      FETCH_REQ:  if (wbAck) stateNext = FETCH_GAP;
      FETCH_GAP:  stateNext = run ? FETCH_REQ : FETCH_IDLE; // no second gap cycle
      default:    stateNext = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= FETCH_IDLE;
      wbAdr       <= '0;
      bundleValid <= 1'b0;
    end else begin
      state       <= stateNext;
      bundleValid <= ackSeen; // one pulse per accepted bundle
      if (ackSeen) begin
        wbAdr <= wbAdr + 1'b1;
      end
    end
  end

  // bundle captured on the ack edge
  always_ff @(posedge clk) begin
    if (ackSeen) begin
      bundle <= wbDatIn;
    end
  end

endmodule

/* source/coreIfs.sv */
/*
  Interfaces between the core's internal blocks.
  regReadIf carries two read ports per lane. Port 2*l is rs1, 2*l+1 is rs2.
*/

// one issue slot feeding one alu lane
interface laneIssueIf;
  import rvIsaPkg::*;
  import corePkg::*;

  logic     valid;
  aluOp_t   op;
  word_t    srcA;
  word_t    srcB;
  regAddr_t rd;

  modport issue (output valid, op, srcA, srcB, rd);
  modport lane  (input  valid, op, srcA, srcB, rd);
endinterface

// operand reads from decode into the register file
interface regReadIf #(
  parameter int LANES = corePkg::DEFAULT_LANES
);
  import rvIsaPkg::*;
  import corePkg::*;

  regAddr_t [2*LANES-1:0] addr;
  word_t    [2*LANES-1:0] data;

  modport request (output addr, input  data);
  modport file    (input  addr, output data);
endinterface

/* source/corePkg.sv */
/*
  Machine state types shared by the core and its testbench.
  DEFAULT_LANES is only a default. The top level passes LANES down.
*/
package corePkg;

  // one integer data word
  typedef logic [31:0] word_t;

  // bus fetcher states
  typedef enum logic [1:0] {
    FETCH_IDLE, // waiting for run
    FETCH_REQ,  // cyc/stb high until ack
    FETCH_GAP   // one dead cycle between bus cycles
  } fetchState_e;

  localparam int DEFAULT_LANES = 2;

endpackage

/* source/rvIsaPkg.sv */
/*
  RV32I encoding used by the execute cluster.
  Only OP and OP-IMM are decoded. Every other opcode is a lane no-op.
  aluOp_t codes are internal and carry no meaning outside the core.
*/
package rvIsaPkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [3:0]  aluOp_t;

  //////////////////////////////////////////////////////////////////////
  // opcodes and funct fields
  //////////////////////////////////////////////////////////////////////
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;

  localparam funct3_t F3_ADD  = 3'b000; // also SUB
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SRL  = 3'b101; // also SRA
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000; // selects SUB / SRA

  // alu operation codes
  localparam aluOp_t ALU_ADD  = 4'd0;
  localparam aluOp_t ALU_SUB  = 4'd1;
  localparam aluOp_t ALU_SLL  = 4'd2;
  localparam aluOp_t ALU_SLT  = 4'd3;
  localparam aluOp_t ALU_SLTU = 4'd4;
  localparam aluOp_t ALU_XOR  = 4'd5;
  localparam aluOp_t ALU_SRL  = 4'd6;
  localparam aluOp_t ALU_SRA  = 4'd7;
  localparam aluOp_t ALU_OR   = 4'd8;
  localparam aluOp_t ALU_AND  = 4'd9;
  localparam aluOp_t ALU_NOP  = 4'd15;

endpackage
